/* Bender.yml */
package:
  name: wiscPipe

sources:
  - include_dirs:
      - hw
    files:
      - hw/wiscPipePkg.sv
      - hw/hazardCheck.sv
      - hw/regFile.sv
      - hw/decodeStage.sv
      - hw/executeStage.sv
      - hw/resultStage.sv
      - hw/wiscPipe.sv

  - target: test
    include_dirs:
      - hw
    files:
      - dv/wiscPipeTb.sv

/* dv/wiscPipeTb.sv */
// Sends kept opcodes only; register fields stay in r0..r3 so that hazards are frequent
`timescale 1ns/1ps

`include "wiscPipe_params.svh"

module wiscPipeTb import wiscPipePkg::*; ();

	localparam int PROG_LEN = 400;
	localparam int TOTAL = PROG_LEN + `WISC_NUM_REGS;
	localparam int SEND_TIMEOUT = 200;
	localparam int DRAIN_TIMEOUT = 2000;

	logic   clk;
	logic   rstN;
	logic   instValid;
	logic   instReady;
	instT   inst;
	logic   resultValid;
	logic   resultReady;
	resultS result;

	// Stimulus and back-pressure streams
	int     seed;
	int     readySeed;

	// Reference ISA state and expected results in program order
	dataT   modelRegs [`WISC_NUM_REGS];
	resultS expQ [$];
	int     recvCount;

	// Result seen last edge while not taken
	logic   heldPending;
	resultS heldResult;

	wiscPipe dut_i (
		.clk(clk), .rstN(rstN),
		.instValid(instValid), .instReady(instReady), .inst(inst),
		.resultValid(resultValid), .resultReady(resultReady), .result(result)
	);

	always #2 clk = ~clk;

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic checkResult(input string testName, input resultS expected, input resultS actual);
		if (actual !== expected) begin
			abortRun($sformatf("ERR %s: expected dest %0d value 0x%h, actual dest %0d value 0x%h",
				testName, expected.dest, expected.value, actual.dest, actual.value));
		end
	endtask

	task automatic checkReg(input regIdxT idx, input dataT actual);
		if (actual !== modelRegs[idx]) begin
			abortRun($sformatf("ERR readback r%0d: expected 0x%h, actual 0x%h",
				idx, modelRegs[idx], actual));
		end
	endtask

	task automatic checkBit(input string testName, input logic expected, input logic actual);
		if (actual !== expected) begin
			abortRun($sformatf("ERR %s: expected %b, actual %b", testName, expected, actual));
		end
	endtask

	// Random kept instruction
	function automatic instT genInst();
		int         kind;
		regIdxT     rs;
		regIdxT     rt;
		regIdxT     rd;
		logic [4:0] imm5;
		logic [7:0] imm8;
		kind = $unsigned($random(seed)) % 10;
		rs = regIdxT'($random(seed) & 3);
		rt = regIdxT'($random(seed) & 3);
		rd = regIdxT'($random(seed) & 3);
		imm5 = 5'($random(seed));
		imm8 = 8'($random(seed));
		case (kind)
			// ADD, SUB, XOR, ANDN by function bits
			0, 1, 2, 3: return {5'b11011, rs, rt, rd, 2'(kind)};
			// ADDI, SUBI, XORI, ANDNI
			4, 5, 6, 7: return {3'b010, 2'(kind - 4), rs, rd, imm5};
			8: return {5'b11000, rs, imm8};
			default: return {5'b10010, rs, imm8};
		endcase
	endfunction

	// ISA rules applied in program order
	task automatic modelStep(input instT w, output resultS res);
		regIdxT rd;
		dataT   a;
		dataT   b;
		dataT   value;
		dataT   simm5;
		dataT   zimm5;
		dataT   simm8;
		dataT   zimm8;
		a = modelRegs[w[10:8]];
		b = modelRegs[w[7:5]];
		simm5 = {{11{w[4]}}, w[4:0]};
		zimm5 = {11'b0, w[4:0]};
		simm8 = {{8{w[7]}}, w[7:0]};
		zimm8 = {8'b0, w[7:0]};
		rd = w[7:5];
		case (w[15:11])
			5'b11011: begin
				rd = w[4:2];
				case (w[1:0])
					2'd0: value = a + b;
					// Rt minus Rs
					2'd1: value = b - a;
					2'd2: value = a ^ b;
					default: value = a & ~b;
				endcase
			end
			5'b01000: value = a + simm5;
			5'b01001: value = simm5 - a;
			5'b01010: value = a ^ zimm5;
			5'b01011: value = a & ~zimm5;
			5'b11000: begin
				rd = w[10:8];
				value = simm8;
			end
			default: begin
				// SLBI keeps the old low byte in the high byte
				rd = w[10:8];
				value = (a << 8) | zimm8;
			end
		endcase
		modelRegs[rd] = value;
		res.dest = rd;
		res.value = value;
	endtask

	// Random gaps in instValid, then hold until accepted
	task automatic sendInst(input instT word);
		int waitCycles;
		while (($random(seed) & 3) == 0) begin
			instValid <= 1'b0;
			@(posedge clk);
		end
		instValid <= 1'b1;
		inst <= word;
		waitCycles = 0;
		do begin
			@(posedge clk);
			waitCycles++;
			if (waitCycles > SEND_TIMEOUT) begin
				abortRun("Timeout: instReady stayed low, decode never took the instruction");
			end
		end while (!instReady);
	endtask

	// Result monitor and back-pressure
	always @(posedge clk) begin
		if (rstN) begin
			if (heldPending) begin
				if (!resultValid) begin
					abortRun("resultValid dropped before the result was taken");
				end
				checkResult("held result", heldResult, result);
			end
			if (resultValid && resultReady) begin
				if (recvCount >= TOTAL || (recvCount < PROG_LEN && expQ.size() == 0)) begin
					abortRun("A result was transferred with no instruction outstanding");
				end else if (recvCount < PROG_LEN) begin
					checkResult($sformatf("result %0d", recvCount), expQ.pop_front(), result);
				end else begin
					// Readback walks r0 upward against the final model state
					if (result.dest !== regIdxT'(recvCount - PROG_LEN)) begin
						abortRun($sformatf("ERR readback order: expected dest %0d, actual dest %0d",
							recvCount - PROG_LEN, result.dest));
					end
					checkReg(result.dest, result.value);
				end
				recvCount++;
			end
			heldPending = resultValid && !resultReady;
			heldResult = result;
			resultReady <= (($random(readySeed) & 3) != 0);
		end
	end

	initial begin
		int     waitCycles;
		instT   word;
		resultS res;
		clk = 1'b0;
		rstN = 1'b0;
		instValid = 1'b0;
		inst = '0;
		resultReady = 1'b0;
		seed = 30;
		readySeed = 30;
		recvCount = 0;
		heldPending = 1'b0;
		heldResult = '0;
		for (int r = 0; r < `WISC_NUM_REGS; r++) begin
			modelRegs[r] = '0;
		end
		repeat (4) @(posedge clk);
		checkBit("reset instReady", 1'b1, instReady);
		checkBit("reset resultValid", 1'b0, resultValid);
		rstN <= 1'b1;
		// Random program
		for (int i = 0; i < PROG_LEN; i++) begin
			word = genInst();
			modelStep(word, res);
			expQ.push_back(res);
			sendInst(word);
		end
		// Readback by an XORI of zero on each register
		for (int r = 0; r < `WISC_NUM_REGS; r++) begin
			word = {5'b01010, 3'(r), 3'(r), 5'b00000};
			sendInst(word);
		end
		instValid <= 1'b0;
		waitCycles = 0;
		while (recvCount < TOTAL) begin
			@(posedge clk);
			waitCycles++;
			if (waitCycles > DRAIN_TIMEOUT) begin
				abortRun("Timeout: the pipeline stopped returning results");
			end
		end
		// Any extra result in the idle tail trips the monitor
		repeat (20) @(posedge clk);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

/* hw/decodeStage.sv */
// Holds one word; unsupported opcodes leave as a non-writing slot and retire nothing
`timescale 1ns/1ps

`include "wiscPipe_params.svh"

module decodeStage import wiscPipePkg::*; (
	input  logic   clk,
	input  logic   rstN,
	input  logic   instValid,
	output logic   instReady,
	input  instT   inst,
	input  logic   advance,
	input  logic   stall,
	output instT   idInst,
	output logic   idValid,
	output regIdxT rdIdxA,
	output regIdxT rdIdxB,
	input  dataT   rdDataA,
	input  dataT   rdDataB,
	output exCtrlS exCtrl
);

	opcodeE opcode;
	logic   accept;
	logic   leave;

	// Word moves on only when the pipe runs and no hazard
	assign leave = idValid && advance && !stall;
	assign instReady = !idValid || leave;
	assign accept = instValid && instReady;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			idValid <= 1'b0;
		end else if (accept) begin
			idValid <= 1'b1;
		end else if (leave) begin
			idValid <= 1'b0;
		end
	end

	// Instruction word, loaded on accept
	always_ff @(posedge clk) begin
		if (accept) begin
			idInst <= inst;
		end
	end

	assign opcode = decodeOpcode(idInst);

	// Rs and Rt ports
	assign rdIdxA = idInst[10:8];
	assign rdIdxB = idInst[7:5];

	always_comb begin
		exCtrl = '0;
		// Bubble while stalled or empty
		exCtrl.valid = idValid && !stall;
		exCtrl.opA = rdDataA;
		case (opcode)
			ALU_R: begin
				// Function bits pick the operation
				exCtrl.aluOp = aluOpE'({1'b0, idInst[1:0]});
				exCtrl.writes = 1'b1;
				exCtrl.dest = idInst[4:2];
				exCtrl.opB = rdDataB;
			end
			ADDI, SUBI: begin
				exCtrl.aluOp = (opcode == ADDI) ? ADD : SUB;
				exCtrl.writes = 1'b1;
				exCtrl.dest = idInst[7:5];
				// Signed 5-bit immediate
				exCtrl.opB = {{(`WISC_DATA_W-5){idInst[4]}}, idInst[4:0]};
			end
			XORI, ANDNI: begin
				exCtrl.aluOp = (opcode == XORI) ? XOR : ANDN;
				exCtrl.writes = 1'b1;
				exCtrl.dest = idInst[7:5];
				// Logic immediates are unsigned
				exCtrl.opB = {{(`WISC_DATA_W-5){1'b0}}, idInst[4:0]};
			end
			LBI: begin
				exCtrl.aluOp = PASS_B;
				exCtrl.writes = 1'b1;
				exCtrl.dest = idInst[10:8];
				exCtrl.opB = {{(`WISC_DATA_W-8){idInst[7]}}, idInst[7:0]};
			end
			SLBI: begin
				exCtrl.aluOp = SHIFT_OR;
				exCtrl.writes = 1'b1;
				exCtrl.dest = idInst[10:8];
				exCtrl.opB = {{(`WISC_DATA_W-8){1'b0}}, idInst[7:0]};
			end
			default: begin
				// Consumed, no write
				exCtrl.writes = 1'b0;
			end
		endcase
	end

	// Source must hold the word until taken
	instHeld: assert property (@(posedge clk) disable iff (!rstN)
		instValid && !instReady |=> !instValid || $stable(inst))
		else $error("decodeStage: inst changed while waiting for instReady");

endmodule

/* hw/executeStage.sv */
// Single-cycle ALU; operands arrive already read and extended from decode
`timescale 1ns/1ps

module executeStage import wiscPipePkg::*; (
	input  logic   clk,
	input  logic   rstN,
	input  logic   advance,
	input  exCtrlS exCtrl,
	output regIdxT exDest,
	output logic   exWrites,
	output wbCtrlS wbCtrl
);

	exCtrlS exReg;
	dataT   aluOut;

	// Frozen together with the rest of the pipe
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			exReg <= '0;
		end else if (advance) begin
			exReg <= exCtrl;
		end
	end

	always_comb begin
		case (exReg.aluOp)
			ADD:      aluOut = exReg.opA + exReg.opB;
			// Rt minus Rs, and imm minus Rs
			SUB:      aluOut = exReg.opB - exReg.opA;
			XOR:      aluOut = exReg.opA ^ exReg.opB;
			ANDN:     aluOut = exReg.opA & ~exReg.opB;
			PASS_B:   aluOut = exReg.opB;
			// Old value moves to the high byte
			SHIFT_OR: aluOut = (exReg.opA << 8) | exReg.opB;
			default:  aluOut = exReg.opB;
		endcase
	end

	// Pending write seen by the hazard check
	assign exDest = exReg.dest;
	assign exWrites = exReg.valid && exReg.writes;

	assign wbCtrl.valid = exReg.valid;
	assign wbCtrl.writes = exReg.writes;
	assign wbCtrl.dest = exReg.dest;
	assign wbCtrl.value = aluOut;

endmodule

/* hw/hazardCheck.sv */
// No forwarding; any read of a register still owned by execute or result stalls decode
`timescale 1ns/1ps

module hazardCheck import wiscPipePkg::*; (
	input  instT   inst,
	input  logic   instValid,
	input  regIdxT exDest,
	input  logic   exWrites,
	input  regIdxT wbDest,
	input  logic   wbWrites,
	output logic   stall
);

	opcodeE opcode;
	regIdxT srcA;
	regIdxT srcB;
	logic   readsA;
	logic   readsB;
	logic   hitA;
	logic   hitB;

	assign opcode = decodeOpcode(inst);

	// Source fields sit at fixed positions
	assign srcA = inst[10:8];
	assign srcB = inst[7:5];

	// Which source fields are actually read
	always_comb begin
		readsA = 1'b0;
		readsB = 1'b0;
		case (opcode)
			// Rs and Rt
			ALU_R: begin
				readsA = 1'b1;
				readsB = 1'b1;
			end
			// Rs only
			ADDI, SUBI, XORI, ANDNI: begin
				readsA = 1'b1;
			end
			// Old Rs value gets shifted up
			SLBI: begin
				readsA = 1'b1;
			end
			// LBI and unsupported words read nothing
			default: begin
				readsA = 1'b0;
				readsB = 1'b0;
			end
		endcase
	end

	// Match against older writers still in flight
	assign hitA = readsA &&
		((exWrites && (exDest == srcA)) || (wbWrites && (wbDest == srcA)));
	assign hitB = readsB &&
		((exWrites && (exDest == srcB)) || (wbWrites && (wbDest == srcB)));

	assign stall = instValid && (hitA || hitB);

endmodule

/* hw/regFile.sv */
// Reads are combinational; a write is seen by a read only after the clock edge
`timescale 1ns/1ps

`include "wiscPipe_params.svh"

module regFile import wiscPipePkg::*; (
	input  logic   clk,
	input  logic   rstN,
	input  regIdxT rdIdxA,
	input  regIdxT rdIdxB,
	output dataT   rdDataA,
	output dataT   rdDataB,
	input  logic   wrEn,
	input  regIdxT wrIdx,
	input  dataT   wrData
);

	// Architectural registers
	dataT regs [`WISC_NUM_REGS];

	// Single write port
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `WISC_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[wrIdx] <= wrData;
		end
	end

	// Two read ports, no bypass
	assign rdDataA = regs[rdIdxA];
	assign rdDataB = regs[rdIdxB];

endmodule

/* hw/resultStage.sv */
// Register write and result transfer share one edge; a stalled result freezes the pipe
`timescale 1ns/1ps

module resultStage import wiscPipePkg::*; (
	input  logic   clk,
	input  logic   rstN,
	input  wbCtrlS wbCtrl,
	output regIdxT wbDest,
	output logic   wbWrites,
	output logic   advance,
	output logic   wrEn,
	output regIdxT wrIdx,
	output dataT   wrData,
	output logic   resultValid,
	input  logic   resultReady,
	output resultS result
);

	wbCtrlS wbReg;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wbReg <= '0;
		end else if (advance) begin
			wbReg <= wbCtrl;
		end
	end

	// Bubbles and non-writing slots retire silently
	assign resultValid = wbReg.valid && wbReg.writes;
	assign advance = !(resultValid && !resultReady);

	// Write lands on the transfer edge
	assign wrEn = resultValid && resultReady;
	assign wrIdx = wbReg.dest;
	assign wrData = wbReg.value;

	// Still checked until written
	assign wbDest = wbReg.dest;
	assign wbWrites = resultValid;

	assign result.dest = wbReg.dest;
	assign result.value = wbReg.value;

endmodule

/* hw/wiscPipe.sv */
// In-order, no forwarding; dependent words wait in decode until the writer retires
`timescale 1ns/1ps

module wiscPipe import wiscPipePkg::*; (
	input  logic   clk,
	input  logic   rstN,
	input  logic   instValid,
	output logic   instReady,
	input  instT   inst,
	output logic   resultValid,
	input  logic   resultReady,
	output resultS result
);

	// Pipe control
	logic   advance;
	logic   stall;

	// Decode side
	instT   idInst;
	logic   idValid;
	regIdxT rdIdxA;
	regIdxT rdIdxB;
	dataT   rdDataA;
	dataT   rdDataB;
	exCtrlS exCtrl;

	// Writers in flight
	regIdxT exDest;
	logic   exWrites;
	wbCtrlS wbCtrl;
	regIdxT wbDest;
	logic   wbWrites;

	// Register write port
	logic   wrEn;
	regIdxT wrIdx;
	dataT   wrData;

	decodeStage uDecode (
		.clk(clk), .rstN(rstN),
		.instValid(instValid), .instReady(instReady), .inst(inst),
		.advance(advance), .stall(stall),
		.idInst(idInst), .idValid(idValid),
		.rdIdxA(rdIdxA), .rdIdxB(rdIdxB), .rdDataA(rdDataA), .rdDataB(rdDataB),
		.exCtrl(exCtrl)
	);

	hazardCheck uHazard (
		.inst(idInst), .instValid(idValid),
		.exDest(exDest), .exWrites(exWrites),
		.wbDest(wbDest), .wbWrites(wbWrites),
		.stall(stall)
	);

	regFile uRegs (
		.clk(clk), .rstN(rstN),
		.rdIdxA(rdIdxA), .rdIdxB(rdIdxB), .rdDataA(rdDataA), .rdDataB(rdDataB),
		.wrEn(wrEn), .wrIdx(wrIdx), .wrData(wrData)
	);

	executeStage uExecute (
		.clk(clk), .rstN(rstN), .advance(advance),
		.exCtrl(exCtrl), .exDest(exDest), .exWrites(exWrites), .wbCtrl(wbCtrl)
	);

	// Also the source of the freeze
	resultStage uResult (
		.clk(clk), .rstN(rstN), .wbCtrl(wbCtrl),
		.wbDest(wbDest), .wbWrites(wbWrites), .advance(advance),
		.wrEn(wrEn), .wrIdx(wrIdx), .wrData(wrData),
		.resultValid(resultValid), .resultReady(resultReady), .result(result)
	);

endmodule

/* hw/wiscPipePkg.sv */
// Only the ALU, immediate, LBI and SLBI opcodes decode; every other opcode maps to OTHER
`include "wiscPipe_params.svh"

package wiscPipePkg;

	// Meaningful widths
	typedef logic [`WISC_INST_W-1:0] instT;
	typedef logic [`WISC_REG_IDX_W-1:0] regIdxT;
	typedef logic [`WISC_DATA_W-1:0] dataT;

	// Major opcodes, encodings match inst[15:11]
	typedef enum logic [`WISC_OPC_W-1:0] {
		ALU_R = 5'b11011,
		ADDI  = 5'b01000,
		SUBI  = 5'b01001,
		XORI  = 5'b01010,
		ANDNI = 5'b01011,
		LBI   = 5'b11000,
		SLBI  = 5'b10010,
		OTHER = 5'b00000
	} opcodeE;

	// ALU functions; low four match the R-format function bits
	typedef enum logic [2:0] {
		ADD      = 3'd0,
		SUB      = 3'd1,
		XOR      = 3'd2,
		ANDN     = 3'd3,
		PASS_B   = 3'd4,
		SHIFT_OR = 3'd5
	} aluOpE;

	// Decode to execute
	typedef struct packed {
		logic   valid;
		aluOpE  aluOp;
		logic   writes;
		regIdxT dest;
		dataT   opA;
		dataT   opB;
	} exCtrlS;

	// Execute to result
	typedef struct packed {
		logic   valid;
		logic   writes;
		regIdxT dest;
		dataT   value;
	} wbCtrlS;

	// Retired register write, as seen at the result port
	typedef struct packed {
		regIdxT dest;
		dataT   value;
	} resultS;

	// Major opcode of a word, unsupported ones fold into OTHER
	function automatic opcodeE decodeOpcode(instT inst);
		case (inst[15:11])
			ALU_R, ADDI, SUBI, XORI, ANDNI, LBI, SLBI: return opcodeE'(inst[15:11]);
			default: return OTHER;
		endcase
	endfunction

endpackage

/* hw/wiscPipe_params.svh */
// Widths are fixed by the 16-bit WISC encoding; changing them breaks the field decode
`ifndef WISC_PIPE_PARAMS_SVH
`define WISC_PIPE_PARAMS_SVH

// Architectural register count
`define WISC_NUM_REGS 8

// Register index width, log2 of the register count
`define WISC_REG_IDX_W 3

// Register and datapath width
`define WISC_DATA_W 16

// Instruction word width
`define WISC_INST_W 16

// Opcode field width, top bits of the word
`define WISC_OPC_W 5

`endif

/* wiscPipe.f */
+incdir+hw
hw/wiscPipePkg.sv
hw/hazardCheck.sv
hw/regFile.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/resultStage.sv
hw/wiscPipe.sv
dv/wiscPipeTb.sv
